// ==== test_input.txt ====
// op addr wdata wmask tcm_sd exp_rdata exp_err, all hex
// op 0 is a write and 1 a read, writes expect rdata 0
0 80000010 11223344 f 0 00000000 0
0 80000010 aabbccdd 5 0 00000000 0
1 80000010 00000000 0 0 11bb33dd 0
0 90000010 55667788 f 0 00000000 0
1 90000010 00000000 0 0 55667788 0
1 80000010 00000000 0 0 11bb33dd 0
0 90000010 deadbeef a 0 00000000 0
1 90000010 00000000 0 0 de66be88 0
0 80000ffc cafef00d f 0 00000000 0
0 80000000 01020304 f 0 00000000 0
1 00001000 00000000 0 0 00001000 0
0 00001000 12345678 f 0 00000000 0
1 00001000 00000000 0 0 12345678 0
1 80001000 00000000 0 0 80001000 0
1 90002000 00000000 0 0 90002000 0
1 7ffffffc 00000000 0 0 7ffffffc 0
1 80000ffc 00000000 0 0 cafef00d 0
1 90000010 00000000 0 0 de66be88 0
1 00001000 00000000 0 0 12345678 0
1 80000000 00000000 0 0 01020304 0
1 80000010 00000000 0 0 11bb33dd 0
1 80000ffc 00000000 0 0 cafef00d 0
0 90000020 0badf00d f 0 00000000 0
1 90000020 00000000 0 0 0badf00d 0
0 80000000 ffffffff f 1 00000000 1
1 80000000 00000000 0 1 00000000 1
0 90000020 ffffffff f 1 00000000 1
1 90000020 00000000 0 1 00000000 1
1 00001000 00000000 0 1 12345678 0
1 80000000 00000000 0 0 01020304 0
1 90000020 00000000 0 0 0badf00d 0

// ==== project.f ====
cpu_cfg_pkg.sv
icb_pkg.sv
tcm_sram.sv
tcm_ctrl.sv
icb_region_split.sv
cpu_top.sv
tb_mem_model.sv
tb_cpu_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the memory system testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cpu_top -f project.f \
  && ./obj_dir/Vtb_cpu_top | tee /dev/stderr | grep "Finished with no errors" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== tb_cpu_top.sv ====
// Memory system testbench
// Reads transactions from test_input.txt, drives the core-side ICB of the
// CPU memory top level and checks every response in command order

`timescale 1ns/1ns
`default_nettype none

module tb_cpu_top;
  import cpu_cfg_pkg::*;
  import icb_pkg::*;

  localparam int itcm_aw    = 12;
  localparam int dtcm_aw    = 12;
  localparam int outs_depth = 4;
  localparam int period     = 100;
  localparam int n_cols     = 7;
  localparam int max_lines  = 64;
  localparam int seed_init  = 32'h33bd_1f2c;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 tcm_sd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic [addr_size-1:0] cmd_addr;
  logic                 cmd_read;
  word_t                cmd_wdata;
  mask_t                cmd_wmask;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic                 rsp_err;
  word_t                rsp_rdata;
  logic                 mem_icb_cmd_valid;
  logic                 mem_icb_cmd_ready;
  logic [addr_size-1:0] mem_icb_cmd_addr;
  logic                 mem_icb_cmd_read;
  word_t                mem_icb_cmd_wdata;
  mask_t                mem_icb_cmd_wmask;
  logic                 mem_icb_rsp_valid;
  logic                 mem_icb_rsp_ready;
  logic                 mem_icb_rsp_err;
  word_t                mem_icb_rsp_rdata;

  // Raw file words, then one entry per transaction
  logic [31:0]          vec [0:n_cols*max_lines-1];
  logic                 rd_a    [max_lines];
  logic [addr_size-1:0] addr_a  [max_lines];
  word_t                wdata_a [max_lines];
  mask_t                wmask_a [max_lines];
  logic                 sd_a    [max_lines];
  word_t                rdata_a [max_lines];
  logic                 err_a   [max_lines];

  integer seed = seed_init;
  int     n_lines = 0;
  int     cur_idx = 0;
  int     rsp_count = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 100;
  int     lat_idx = 0;
  logic   lat_check = 1'b0;
  int     exp_q [$];

  cpu_top #(
    .itcm_aw   (itcm_aw),
    .dtcm_aw   (dtcm_aw),
    .outs_depth(outs_depth)
  ) dut0 (.*);

  tb_mem_model #(
    .seed_init(seed_init)
  ) u_mem (.*);

  initial begin
    forever #(period/2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // Region by address range, everything else is system memory
  function automatic icb_target_e target_of(input logic [addr_size-1:0] a);
    if (a >= itcm_base && a < itcm_base + (32'd1 << itcm_aw)) begin
      return tgt_itcm;
    end
    if (a >= dtcm_base && a < dtcm_base + (32'd1 << dtcm_aw)) begin
      return tgt_dtcm;
    end
    return tgt_mem;
  endfunction

  function automatic string test_name(input int i);
    icb_target_e t;
    t = target_of(addr_a[i]);
    return $sformatf("t%0d_%s_%s", i, t.name(), rd_a[i] ? "read" : "write");
  endfunction

  task automatic load_vectors();
    // Fill never matches a valid op, so it marks the end of the file
    for (int i = 0; i < n_cols*max_lines; i++) begin
      vec[i] = 32'hf000_0000 | i;
    end
    $readmemh("test_input.txt", vec);
    while (n_lines < max_lines && vec[n_lines*n_cols] <= 32'd1) begin
      rd_a[n_lines]    = vec[n_lines*n_cols][0];
      addr_a[n_lines]  = vec[n_lines*n_cols+1];
      wdata_a[n_lines] = vec[n_lines*n_cols+2];
      wmask_a[n_lines] = vec[n_lines*n_cols+3][mw-1:0];
      sd_a[n_lines]    = vec[n_lines*n_cols+4][0];
      rdata_a[n_lines] = vec[n_lines*n_cols+5];
      err_a[n_lines]   = vec[n_lines*n_cols+6][0];
      n_lines++;
    end
    if (n_lines == 0) begin
      stop_with_failure("No transactions could be read from test_input.txt");
    end
  endtask

  task automatic check_idle();
    repeat (4) begin
      @(posedge clk);
      assert (!rsp_valid) else
        stop_with_failure("Error idle_after_reset: rsp_valid expected 0 actual 1");
      assert (!mem_icb_cmd_valid) else
        stop_with_failure("Error idle_after_reset: mem_icb_cmd_valid expected 0 actual 1");
      assert (cmd_ready) else
        stop_with_failure("Error idle_after_reset: cmd_ready expected 1 actual 0");
    end
  endtask

  // Issue each command as soon as the previous one is taken
  task automatic drive_all();
    logic taken;
    for (int i = 0; i < n_lines; i++) begin
      @(negedge clk);
      cur_idx   = i;
      cmd_valid = 1'b1;
      cmd_addr  = addr_a[i];
      cmd_read  = rd_a[i];
      cmd_wdata = wdata_a[i];
      cmd_wmask = wmask_a[i];
      tcm_sd    = sd_a[i];
      taken     = 1'b0;
      while (!taken) begin
        @(posedge clk);
        taken = cmd_ready;
      end
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Back-pressure, timeout and response checks

  always @(negedge clk) begin
    rsp_ready = ($random(seed) & 3) != 0;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_with_failure($sformatf("Timeout after %0d cycles, the run did not finish", cycle_cnt));
    end
  end

  always @(posedge clk) begin
    int   idx;
    logic was_idle;
    if (arst_n) begin
      was_idle = (exp_q.size() == 0);
      if (lat_check) begin
        assert (rsp_valid) else
          stop_with_failure($sformatf("Error %s: rsp_valid expected 1 actual 0",
                                      test_name(lat_idx)));
      end
      lat_check = 1'b0;
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("A response arrived with no command outstanding");
        end
        idx = exp_q.pop_front();
        assert (rsp_err === err_a[idx]) else
          stop_with_failure($sformatf("Error %s: err expected %0b actual %0b",
                                      test_name(idx), err_a[idx], rsp_err));
        assert (rsp_rdata === rdata_a[idx]) else
          stop_with_failure($sformatf("Error %s: rdata expected %08h actual %08h",
                                      test_name(idx), rdata_a[idx], rsp_rdata));
        rsp_count++;
      end
      if (mem_icb_cmd_valid) begin
        assert (target_of(cmd_addr) == tgt_mem) else
          stop_with_failure("A TCM command showed up on the memory port");
        assert (mem_icb_cmd_addr === cmd_addr) else
          stop_with_failure($sformatf("Error %s: mem address expected %08h actual %08h",
                                      test_name(cur_idx), cmd_addr, mem_icb_cmd_addr));
        assert (mem_icb_cmd_read === cmd_read) else
          stop_with_failure($sformatf("Error %s: mem read expected %0b actual %0b",
                                      test_name(cur_idx), cmd_read, mem_icb_cmd_read));
        assert (mem_icb_cmd_wdata === cmd_wdata) else
          stop_with_failure($sformatf("Error %s: mem wdata expected %08h actual %08h",
                                      test_name(cur_idx), cmd_wdata, mem_icb_cmd_wdata));
        assert (mem_icb_cmd_wmask === cmd_wmask) else
          stop_with_failure($sformatf("Error %s: mem wmask expected %h actual %h",
                                      test_name(cur_idx), cmd_wmask, mem_icb_cmd_wmask));
      end
      if (cmd_valid && cmd_ready) begin
        exp_q.push_back(cur_idx);
        // TCM answer is due next cycle when nothing older is pending
        lat_check = was_idle && (target_of(cmd_addr) != tgt_mem);
        lat_idx   = cur_idx;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    arst_n    = 1'b0;
    tcm_sd    = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr  = itcm_base;
    cmd_read  = 1'b1;
    cmd_wdata = '0;
    cmd_wmask = '0;
    rsp_ready = 1'b0;
    load_vectors();
    cycle_limit = 40 * n_lines + 100;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_idle();
    drive_all();
    while (rsp_count < n_lines) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    if (rsp_count == n_lines && !rsp_valid) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_with_failure("A response came after the last transaction");
    end
  end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
// System memory model
// ICB responder for the memory port with a sparse word store, one command
// at a time and a random response delay of 0 to 3 cycles

`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
  parameter int seed_init = 1
) (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire                              mem_icb_cmd_valid,
  output logic                             mem_icb_cmd_ready,
  input  wire [cpu_cfg_pkg::addr_size-1:0] mem_icb_cmd_addr,
  input  wire                              mem_icb_cmd_read,
  input  wire cpu_cfg_pkg::word_t          mem_icb_cmd_wdata,
  input  wire cpu_cfg_pkg::mask_t          mem_icb_cmd_wmask,
  output logic                             mem_icb_rsp_valid,
  input  wire                              mem_icb_rsp_ready,
  output logic                             mem_icb_rsp_err,
  output cpu_cfg_pkg::word_t               mem_icb_rsp_rdata
);
  import cpu_cfg_pkg::*;

  word_t                store [logic [addr_size-1:0]];
  integer               seed = seed_init;
  int                   delay = 0;
  logic                 busy = 1'b0;
  logic                 in_reset = 1'b1;
  logic                 cmd_hsk;
  logic                 rsp_hsk;
  logic [addr_size-1:0] key;
  word_t                cur;
  word_t                rdata_n;

  initial begin
    mem_icb_cmd_ready = 1'b0;
    mem_icb_rsp_valid = 1'b0;
    mem_icb_rsp_err   = 1'b0;
    mem_icb_rsp_rdata = '0;
    forever begin
      @(posedge clk);
      in_reset = !arst_n;
      cmd_hsk  = mem_icb_cmd_valid && mem_icb_cmd_ready;
      rsp_hsk  = mem_icb_rsp_valid && mem_icb_rsp_ready;
      if (cmd_hsk) begin
        // A word never written reads back as its own address
        key     = {mem_icb_cmd_addr[addr_size-1:2], 2'b00};
        cur     = store.exists(key) ? store[key] : mem_icb_cmd_addr;
        rdata_n = '0;
        if (mem_icb_cmd_read) begin
          rdata_n = cur;
        end else begin
          for (int b = 0; b < mw; b++) begin
            if (mem_icb_cmd_wmask[b]) begin
              cur[b*8 +: 8] = mem_icb_cmd_wdata[b*8 +: 8];
            end
          end
          store[key] = cur;
        end
      end
      @(negedge clk);
      if (in_reset) begin
        busy              = 1'b0;
        mem_icb_rsp_valid = 1'b0;
      end else begin
        if (rsp_hsk) begin
          mem_icb_rsp_valid = 1'b0;
          busy              = 1'b0;
        end
        if (cmd_hsk) begin
          busy              = 1'b1;
          delay             = $random(seed) & 3;
          mem_icb_rsp_rdata = rdata_n;
        end
        // Count down the delay, then raise valid
        if (busy && !mem_icb_rsp_valid) begin
          if (delay == 0) begin
            mem_icb_rsp_valid = 1'b1;
          end else begin
            delay = delay - 1;
          end
        end
      end
      mem_icb_cmd_ready = !in_reset && !busy;
    end
  end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
// CPU memory top level
// Core-side ICB enters the region splitter, which feeds the ITCM and DTCM
// controllers and the system memory port.

`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
  parameter int itcm_aw    = cpu_cfg_pkg::tcm_aw_dflt,
  parameter int dtcm_aw    = cpu_cfg_pkg::tcm_aw_dflt,
  parameter int outs_depth = 4
) (
  input  wire                                   clk,
  input  wire                                   arst_n,
  input  wire                                   tcm_sd,
  // Core side
  input  wire                                   cmd_valid,
  output logic                                  cmd_ready,
  input  wire [cpu_cfg_pkg::addr_size-1:0]      cmd_addr,
  input  wire                                   cmd_read,
  input  wire cpu_cfg_pkg::word_t               cmd_wdata,
  input  wire cpu_cfg_pkg::mask_t               cmd_wmask,
  output logic                                  rsp_valid,
  input  wire                                   rsp_ready,
  output logic                                  rsp_err,
  output cpu_cfg_pkg::word_t                    rsp_rdata,
  // System memory
  output logic                                  mem_icb_cmd_valid,
  input  wire                                   mem_icb_cmd_ready,
  output logic [cpu_cfg_pkg::addr_size-1:0]     mem_icb_cmd_addr,
  output logic                                  mem_icb_cmd_read,
  output cpu_cfg_pkg::word_t                    mem_icb_cmd_wdata,
  output cpu_cfg_pkg::mask_t                    mem_icb_cmd_wmask,
  input  wire                                   mem_icb_rsp_valid,
  output logic                                  mem_icb_rsp_ready,
  input  wire                                   mem_icb_rsp_err,
  input  wire cpu_cfg_pkg::word_t               mem_icb_rsp_rdata
);
  import cpu_cfg_pkg::*;

  logic               itcm_cmd_valid;
  logic               itcm_cmd_ready;
  logic [itcm_aw-1:0] itcm_cmd_addr;
  logic               itcm_cmd_read;
  word_t              itcm_cmd_wdata;
  mask_t              itcm_cmd_wmask;
  logic               itcm_rsp_valid;
  logic               itcm_rsp_ready;
  logic               itcm_rsp_err;
  word_t              itcm_rsp_rdata;

  logic               dtcm_cmd_valid;
  logic               dtcm_cmd_ready;
  logic [dtcm_aw-1:0] dtcm_cmd_addr;
  logic               dtcm_cmd_read;
  word_t              dtcm_cmd_wdata;
  mask_t              dtcm_cmd_wmask;
  logic               dtcm_rsp_valid;
  logic               dtcm_rsp_ready;
  logic               dtcm_rsp_err;
  word_t              dtcm_rsp_rdata;

  icb_region_split #(
    .itcm_aw   (itcm_aw),
    .dtcm_aw   (dtcm_aw),
    .outs_depth(outs_depth)
  ) u_split (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_addr      (cmd_addr),
    .cmd_read      (cmd_read),
    .cmd_wdata     (cmd_wdata),
    .cmd_wmask     (cmd_wmask),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_err       (rsp_err),
    .rsp_rdata     (rsp_rdata),
    .itcm_cmd_valid(itcm_cmd_valid),
    .itcm_cmd_ready(itcm_cmd_ready),
    .itcm_cmd_addr (itcm_cmd_addr),
    .itcm_cmd_read (itcm_cmd_read),
    .itcm_cmd_wdata(itcm_cmd_wdata),
    .itcm_cmd_wmask(itcm_cmd_wmask),
    .itcm_rsp_valid(itcm_rsp_valid),
    .itcm_rsp_ready(itcm_rsp_ready),
    .itcm_rsp_err  (itcm_rsp_err),
    .itcm_rsp_rdata(itcm_rsp_rdata),
    .dtcm_cmd_valid(dtcm_cmd_valid),
    .dtcm_cmd_ready(dtcm_cmd_ready),
    .dtcm_cmd_addr (dtcm_cmd_addr),
    .dtcm_cmd_read (dtcm_cmd_read),
    .dtcm_cmd_wdata(dtcm_cmd_wdata),
    .dtcm_cmd_wmask(dtcm_cmd_wmask),
    .dtcm_rsp_valid(dtcm_rsp_valid),
    .dtcm_rsp_ready(dtcm_rsp_ready),
    .dtcm_rsp_err  (dtcm_rsp_err),
    .dtcm_rsp_rdata(dtcm_rsp_rdata),
    .mem_cmd_valid (mem_icb_cmd_valid),
    .mem_cmd_ready (mem_icb_cmd_ready),
    .mem_cmd_addr  (mem_icb_cmd_addr),
    .mem_cmd_read  (mem_icb_cmd_read),
    .mem_cmd_wdata (mem_icb_cmd_wdata),
    .mem_cmd_wmask (mem_icb_cmd_wmask),
    .mem_rsp_valid (mem_icb_rsp_valid),
    .mem_rsp_ready (mem_icb_rsp_ready),
    .mem_rsp_err   (mem_icb_rsp_err),
    .mem_rsp_rdata (mem_icb_rsp_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Tightly coupled memories

  tcm_ctrl #(
    .aw(itcm_aw)
  ) u_itcm (
    .clk      (clk),
    .arst_n   (arst_n),
    .tcm_sd   (tcm_sd),
    .cmd_valid(itcm_cmd_valid),
    .cmd_ready(itcm_cmd_ready),
    .cmd_addr (itcm_cmd_addr),
    .cmd_read (itcm_cmd_read),
    .cmd_wdata(itcm_cmd_wdata),
    .cmd_wmask(itcm_cmd_wmask),
    .rsp_valid(itcm_rsp_valid),
    .rsp_ready(itcm_rsp_ready),
    .rsp_err  (itcm_rsp_err),
    .rsp_rdata(itcm_rsp_rdata)
  );

  tcm_ctrl #(
    .aw(dtcm_aw)
  ) u_dtcm (
    .clk      (clk),
    .arst_n   (arst_n),
    .tcm_sd   (tcm_sd),
    .cmd_valid(dtcm_cmd_valid),
    .cmd_ready(dtcm_cmd_ready),
    .cmd_addr (dtcm_cmd_addr),
    .cmd_read (dtcm_cmd_read),
    .cmd_wdata(dtcm_cmd_wdata),
    .cmd_wmask(dtcm_cmd_wmask),
    .rsp_valid(dtcm_rsp_valid),
    .rsp_ready(dtcm_rsp_ready),
    .rsp_err  (dtcm_rsp_err),
    .rsp_rdata(dtcm_rsp_rdata)
  );

endmodule

`default_nettype wire

// ==== icb_region_split.sv ====
// ICB region splitter
// Decodes the command address into ITCM, DTCM or system memory and keeps
// a queue of outstanding targets so that responses return in command order.

`timescale 1ns/1ns
`default_nettype none

module icb_region_split #(
  parameter int itcm_aw    = cpu_cfg_pkg::tcm_aw_dflt,
  parameter int dtcm_aw    = cpu_cfg_pkg::tcm_aw_dflt,
  parameter int outs_depth = 4
) (
  input  wire                                   clk,
  input  wire                                   arst_n,
  // Core side
  input  wire                                   cmd_valid,
  output logic                                  cmd_ready,
  input  wire [cpu_cfg_pkg::addr_size-1:0]      cmd_addr,
  input  wire                                   cmd_read,
  input  wire cpu_cfg_pkg::word_t               cmd_wdata,
  input  wire cpu_cfg_pkg::mask_t               cmd_wmask,
  output logic                                  rsp_valid,
  input  wire                                   rsp_ready,
  output logic                                  rsp_err,
  output cpu_cfg_pkg::word_t                    rsp_rdata,
  // ITCM
  output logic                                  itcm_cmd_valid,
  input  wire                                   itcm_cmd_ready,
  output logic [itcm_aw-1:0]                    itcm_cmd_addr,
  output logic                                  itcm_cmd_read,
  output cpu_cfg_pkg::word_t                    itcm_cmd_wdata,
  output cpu_cfg_pkg::mask_t                    itcm_cmd_wmask,
  input  wire                                   itcm_rsp_valid,
  output logic                                  itcm_rsp_ready,
  input  wire                                   itcm_rsp_err,
  input  wire cpu_cfg_pkg::word_t               itcm_rsp_rdata,
  // DTCM
  output logic                                  dtcm_cmd_valid,
  input  wire                                   dtcm_cmd_ready,
  output logic [dtcm_aw-1:0]                    dtcm_cmd_addr,
  output logic                                  dtcm_cmd_read,
  output cpu_cfg_pkg::word_t                    dtcm_cmd_wdata,
  output cpu_cfg_pkg::mask_t                    dtcm_cmd_wmask,
  input  wire                                   dtcm_rsp_valid,
  output logic                                  dtcm_rsp_ready,
  input  wire                                   dtcm_rsp_err,
  input  wire cpu_cfg_pkg::word_t               dtcm_rsp_rdata,
  // System memory
  output logic                                  mem_cmd_valid,
  input  wire                                   mem_cmd_ready,
  output logic [cpu_cfg_pkg::addr_size-1:0]     mem_cmd_addr,
  output logic                                  mem_cmd_read,
  output cpu_cfg_pkg::word_t                    mem_cmd_wdata,
  output cpu_cfg_pkg::mask_t                    mem_cmd_wmask,
  input  wire                                   mem_rsp_valid,
  output logic                                  mem_rsp_ready,
  input  wire                                   mem_rsp_err,
  input  wire cpu_cfg_pkg::word_t               mem_rsp_rdata
);
  import cpu_cfg_pkg::*;
  import icb_pkg::*;

  localparam int pw = (outs_depth > 1) ? $clog2(outs_depth) : 1;
  localparam int cw = $clog2(outs_depth + 1);

  icb_target_e cmd_tgt;
  icb_target_e last_tgt;
  icb_target_e q_head;
  icb_target_e q_mem [0:outs_depth-1];
  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic [cw-1:0] q_cnt;
  logic          q_empty;
  logic          q_full;
  logic          order_ok;
  logic          tgt_cmd_ready;
  logic          head_valid;
  icb_rsp_t      head_rsp;
  logic          push;
  logic          pop;
  logic [2:0]    tgt_rsp_vld;

  //////////////////////////////////////////////////////////////////////
  // Address decode

  always_comb begin
    if (cmd_addr[addr_size-1:itcm_aw] == itcm_base[addr_size-1:itcm_aw]) begin
      cmd_tgt = tgt_itcm;
    end else if (cmd_addr[addr_size-1:dtcm_aw] == dtcm_base[addr_size-1:dtcm_aw]) begin
      cmd_tgt = tgt_dtcm;
    end else begin
      cmd_tgt = tgt_mem;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command routing

  // Switching target is allowed only once everything older has drained
  assign q_empty  = (q_cnt == '0);
  assign q_full   = (q_cnt == cw'(outs_depth));
  assign order_ok = !q_full && (q_empty || cmd_tgt == last_tgt);

  always_comb begin
    case (cmd_tgt)
      tgt_itcm: tgt_cmd_ready = itcm_cmd_ready;
      tgt_dtcm: tgt_cmd_ready = dtcm_cmd_ready;
      default:  tgt_cmd_ready = mem_cmd_ready;
    endcase
  end

  assign cmd_ready      = order_ok && tgt_cmd_ready;
  assign itcm_cmd_valid = cmd_valid && order_ok && (cmd_tgt == tgt_itcm);
  assign dtcm_cmd_valid = cmd_valid && order_ok && (cmd_tgt == tgt_dtcm);
  assign mem_cmd_valid  = cmd_valid && order_ok && (cmd_tgt == tgt_mem);

  assign itcm_cmd_addr  = cmd_addr[itcm_aw-1:0];
  assign itcm_cmd_read  = cmd_read;
  assign itcm_cmd_wdata = cmd_wdata;
  assign itcm_cmd_wmask = cmd_wmask;
  assign dtcm_cmd_addr  = cmd_addr[dtcm_aw-1:0];
  assign dtcm_cmd_read  = cmd_read;
  assign dtcm_cmd_wdata = cmd_wdata;
  assign dtcm_cmd_wmask = cmd_wmask;
  assign mem_cmd_addr   = cmd_addr;
  assign mem_cmd_read   = cmd_read;
  assign mem_cmd_wdata  = cmd_wdata;
  assign mem_cmd_wmask  = cmd_wmask;

  //////////////////////////////////////////////////////////////////////
  // Order queue

  assign push   = cmd_valid && cmd_ready;
  assign pop    = rsp_valid && rsp_ready;
  assign q_head = q_mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      q_cnt    <= '0;
      last_tgt <= tgt_mem;
    end else begin
      if (push) begin
        wr_ptr   <= (wr_ptr == pw'(outs_depth - 1)) ? '0 : wr_ptr + 1'b1;
        last_tgt <= cmd_tgt;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == pw'(outs_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (pop && !push) begin
        q_cnt <= q_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= cmd_tgt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response steering

  always_comb begin
    case (q_head)
      tgt_itcm: begin
        head_valid = itcm_rsp_valid;
        head_rsp   = '{err: itcm_rsp_err, rdata: itcm_rsp_rdata};
      end
      tgt_dtcm: begin
        head_valid = dtcm_rsp_valid;
        head_rsp   = '{err: dtcm_rsp_err, rdata: dtcm_rsp_rdata};
      end
      default: begin
        head_valid = mem_rsp_valid;
        head_rsp   = '{err: mem_rsp_err, rdata: mem_rsp_rdata};
      end
    endcase
  end

  assign rsp_valid = !q_empty && head_valid;
  assign rsp_err   = head_rsp.err;
  assign rsp_rdata = head_rsp.rdata;

  // Targets not at the head see ready low and wait
  assign itcm_rsp_ready = rsp_ready && !q_empty && (q_head == tgt_itcm);
  assign dtcm_rsp_ready = rsp_ready && !q_empty && (q_head == tgt_dtcm);
  assign mem_rsp_ready  = rsp_ready && !q_empty && (q_head == tgt_mem);

  assign tgt_rsp_vld = {mem_rsp_valid, dtcm_rsp_valid, itcm_rsp_valid};

  // A push never lands on the entry still waiting at the head
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> q_empty || (wr_ptr != rd_ptr));

  // Only the target at the head may present a response
  a_rsp_from_head: assert property (@(posedge clk) disable iff (!arst_n)
    (tgt_rsp_vld != 3'b000) |-> (!q_empty && tgt_rsp_vld == (3'b001 << q_head)));

endmodule

`default_nettype wire

// ==== tcm_ctrl.sv ====
// TCM controller
// ICB slave in front of one TCM SRAM, one command in flight at a time.
// While tcm_sd is high a command completes with an error and the SRAM
// stays idle.

`timescale 1ns/1ns
`default_nettype none

module tcm_ctrl #(
  parameter int aw = cpu_cfg_pkg::tcm_aw_dflt
) (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     tcm_sd,
  input  wire                     cmd_valid,
  output logic                    cmd_ready,
  input  wire [aw-1:0]            cmd_addr,
  input  wire                     cmd_read,
  input  wire cpu_cfg_pkg::word_t cmd_wdata,
  input  wire cpu_cfg_pkg::mask_t cmd_wmask,
  output logic                    rsp_valid,
  input  wire                     rsp_ready,
  output logic                    rsp_err,
  output cpu_cfg_pkg::word_t      rsp_rdata
);
  import cpu_cfg_pkg::*;

  // Byte offset bits dropped from the bus address
  localparam int ow     = $clog2(mw);
  localparam int ram_aw = aw - ow;

  logic              cmd_hsk;
  logic              rd_q;
  logic              sd_q;
  logic              fresh_q;
  logic              ram_cs;
  logic              ram_we;
  logic [ram_aw-1:0] ram_addr;
  mask_t             ram_wem;
  word_t             ram_din;
  word_t             ram_dout;
  word_t             hold_q;
  word_t             rdata_src;

  //////////////////////////////////////////////////////////////////////
  // Command side

  assign cmd_ready = !rsp_valid || rsp_ready;
  assign cmd_hsk   = cmd_valid && cmd_ready;

  // Shutdown keeps the SRAM deselected
  assign ram_cs   = cmd_hsk && !tcm_sd;
  assign ram_we   = !cmd_read;
  assign ram_addr = cmd_addr[aw-1:ow];
  assign ram_wem  = cmd_wmask;
  assign ram_din  = cmd_wdata;

  tcm_sram #(
    .aw(ram_aw)
  ) u_sram (
    .clk     (clk),
    .ram_cs  (ram_cs),
    .ram_we  (ram_we),
    .ram_addr(ram_addr),
    .ram_wem (ram_wem),
    .ram_din (ram_din),
    .ram_dout(ram_dout)
  );

  //////////////////////////////////////////////////////////////////////
  // Response side

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
      rd_q      <= 1'b0;
      sd_q      <= 1'b0;
      fresh_q   <= 1'b0;
    end else begin
      fresh_q <= cmd_hsk;
      if (cmd_hsk) begin
        rsp_valid <= 1'b1;
        rd_q      <= cmd_read;
        sd_q      <= tcm_sd;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  // SRAM output is live only in the first response cycle
  always_ff @(posedge clk) begin
    if (fresh_q) begin
      hold_q <= ram_dout;
    end
  end

  assign rdata_src = fresh_q ? ram_dout : hold_q;
  assign rsp_err   = sd_q;
  // Writes and shut-down accesses return zero
  assign rsp_rdata = (rd_q && !sd_q) ? rdata_src : '0;

  // A stalled response stays put until taken
  a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err));

endmodule

`default_nettype wire

// ==== tcm_sram.sv ====
// TCM SRAM
// Synchronous single-port RAM with a byte write mask and a registered read port

`timescale 1ns/1ns
`default_nettype none

module tcm_sram #(
  parameter int aw = 10
) (
  input  wire                     clk,
  input  wire                     ram_cs,
  input  wire                     ram_we,
  input  wire [aw-1:0]            ram_addr,
  input  wire cpu_cfg_pkg::mask_t ram_wem,
  input  wire cpu_cfg_pkg::word_t ram_din,
  output cpu_cfg_pkg::word_t      ram_dout
);
  import cpu_cfg_pkg::*;

  word_t mem [0:(1<<aw)-1];

  // Byte lanes with their mask bit set are written
  always_ff @(posedge clk) begin
    if (ram_cs && ram_we) begin
      for (int b = 0; b < mw; b++) begin
        if (ram_wem[b]) begin
          mem[ram_addr][b*8 +: 8] <= ram_din[b*8 +: 8];
        end
      end
    end
  end

  // Read data shows up the cycle after the select
  always_ff @(posedge clk) begin
    if (ram_cs && !ram_we) begin
      ram_dout <= mem[ram_addr];
    end
  end

endmodule

`default_nettype wire

// ==== icb_pkg.sv ====
// ICB helper types
// Target encoding for the region splitter and the response bundle it steers

`default_nettype none

package icb_pkg;

  // Targets behind the region splitter
  typedef enum logic [1:0] {
    tgt_itcm = 2'd0,
    tgt_dtcm = 2'd1,
    tgt_mem  = 2'd2
  } icb_target_e;

  // Response payload as returned to the core side
  typedef struct packed {
    logic               err;
    cpu_cfg_pkg::word_t rdata;
  } icb_rsp_t;

endpackage

`default_nettype wire

// ==== cpu_cfg_pkg.sv ====
// CPU memory system configuration
// Bus widths, TCM sizes and the address map shared by the memory blocks

`default_nettype none

package cpu_cfg_pkg;

  // Bus widths
  localparam int xlen      = 32;
  localparam int addr_size = 32;
  localparam int mw        = xlen / 8;

  // Region bases, each TCM sits at the bottom of its region
  localparam logic [addr_size-1:0] itcm_base = 32'h8000_0000;
  localparam logic [addr_size-1:0] dtcm_base = 32'h9000_0000;

  // Default TCM byte address width, 4 KB per TCM
  localparam int tcm_aw_dflt = 12;

  typedef logic [xlen-1:0] word_t;
  typedef logic [mw-1:0]   mask_t;

endpackage

`default_nettype wire
